// File: msg_subsys.f
design/msg_pkg.sv
design/msg_axil_regs.sv
design/msg_packer.sv
design/msg_fifo.sv
design/msg_absorber.sv
design/msg_subsys_top.sv
verif/tb_msg_subsys.sv

// File: Bender.yml
package:
  name: msg_subsys

sources:
  - target: any(rtl, test)
    files:
      - design/msg_pkg.sv
      - design/msg_axil_regs.sv
      - design/msg_packer.sv
      - design/msg_fifo.sv
      - design/msg_absorber.sv
      - design/msg_subsys_top.sv
  - target: test
    files:
      - verif/tb_msg_subsys.sv

// File: verif/tb_msg_subsys.sv
`timescale 1ns/1ps

module tb_msg_subsys;

  localparam int HalfPeriod    = 10;
  localparam int WaitLimit     = 50;
  localparam int DonePollLimit = 100;

  logic               clk;
  logic               rst_n;
  msg_pkg::addr_t     awaddr;
  logic               awvalid;
  logic               awready;
  msg_pkg::msg_word_t wdata;
  msg_pkg::msg_strb_t wstrb;
  logic               wvalid;
  logic               wready;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;
  msg_pkg::addr_t     araddr;
  logic               arvalid;
  logic               arready;
  msg_pkg::msg_word_t rdata;
  logic [1:0]         rresp;
  logic               rvalid;
  logic               rready;

  // Expected Fletcher sums and byte count
  int unsigned model_sum1;
  int unsigned model_sum2;
  int unsigned model_count;
  int unsigned seed_val;

  msg_subsys_top dut_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wstrb_i   (wstrb),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready)
  );

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
  endtask

  // Responses must hold until the master takes them
  assert property (@(posedge clk) disable iff (!rst_n) (bvalid && !bready) |=> bvalid)
    else abort_run($sformatf("[FAIL] %0t ns: bvalid dropped before bready", $time));
  assert property (@(posedge clk) disable iff (!rst_n) (rvalid && !rready) |=> rvalid)
    else abort_run($sformatf("[FAIL] %0t ns: rvalid dropped before rready", $time));

  // Address and data taken together, only on a request and with no response pending
  assert property (@(posedge clk) disable iff (!rst_n) awready == wready)
    else abort_run($sformatf("[FAIL] %0t ns: awready and wready differ", $time));
  assert property (@(posedge clk) disable iff (!rst_n)
                   awready |-> (awvalid && wvalid && !bvalid))
    else abort_run($sformatf("[FAIL] %0t ns: write taken out of turn", $time));
  // Write response one cycle after acceptance, and never without one
  assert property (@(posedge clk) disable iff (!rst_n) awready |=> bvalid)
    else abort_run($sformatf("[FAIL] %0t ns: bvalid missing after accept", $time));
  assert property (@(posedge clk) disable iff (!rst_n) (!bvalid && !awready) |=> !bvalid)
    else abort_run($sformatf("[FAIL] %0t ns: bvalid raised without accept", $time));

  // Read address taken only on a request and with no response pending
  assert property (@(posedge clk) disable iff (!rst_n) arready |-> (arvalid && !rvalid))
    else abort_run($sformatf("[FAIL] %0t ns: read taken out of turn", $time));
  assert property (@(posedge clk) disable iff (!rst_n) arready |=> rvalid)
    else abort_run($sformatf("[FAIL] %0t ns: rvalid missing after accept", $time));
  assert property (@(posedge clk) disable iff (!rst_n) (!rvalid && !arready) |=> !rvalid)
    else abort_run($sformatf("[FAIL] %0t ns: rvalid raised without accept", $time));

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite master, called and left on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic axi_write(input msg_pkg::addr_t addr, input msg_pkg::msg_word_t data,
                           input msg_pkg::msg_strb_t strb, output logic [1:0] resp);
    int waited;
    int gap;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    @(negedge clk);
    // A raised bvalid means both channels were taken
    while (!bvalid) begin
      if (waited == WaitLimit) begin
        abort_run("Timeout: write address and data were never accepted");
      end
      waited++;
      @(negedge clk);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp    = bresp;
    // Random delay on bready
    gap = $urandom % 3;
    repeat (gap) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input msg_pkg::addr_t addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    int gap;
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!rvalid) begin
      if (waited == WaitLimit) begin
        abort_run("Timeout: read data never returned");
      end
      waited++;
      @(negedge clk);
    end
    arvalid = 1'b0;
    data    = rdata;
    resp    = rresp;
    gap = $urandom % 3;
    repeat (gap) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  task automatic model_reset();
    model_sum1  = 0;
    model_sum2  = 0;
    model_count = 0;
  endtask

  // Bytes in lane order, sum1 first, then sum2 with the new sum1
  task automatic model_absorb(input msg_pkg::msg_word_t data, input msg_pkg::msg_strb_t strb);
    for (int lane = 0; lane < msg_pkg::MsgBytes; lane++) begin
      if (strb[lane]) begin
        model_sum1  = (model_sum1 + data[8*lane +: 8]) % 65536;
        model_sum2  = (model_sum2 + model_sum1) % 65536;
        model_count = model_count + 1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequences
  //////////////////////////////////////////////////////////////////////

  task automatic send_message(input msg_pkg::msg_word_t data, input msg_pkg::msg_strb_t strb);
    logic [1:0] resp;
    axi_write(msg_pkg::AddrMsg, data, strb, resp);
    check_equal("MSG write response", {30'b0, resp}, {30'b0, msg_pkg::RespOkay});
    model_absorb(data, strb);
  endtask

  task automatic send_random_words(input int count);
    msg_pkg::msg_word_t data;
    msg_pkg::msg_strb_t strb;
    for (int i = 0; i < count; i++) begin
      data = $urandom;
      // Any of the 15 nonzero strobe patterns
      strb = msg_pkg::msg_strb_t'(($urandom % 15) + 1);
      send_message(data, strb);
    end
  endtask

  task automatic write_ctrl_bit(input int bit_pos);
    logic [1:0]  resp;
    logic [31:0] ctrl;
    ctrl = '0;
    ctrl[bit_pos] = 1'b1;
    axi_write(msg_pkg::AddrCtrl, ctrl, 4'hF, resp);
    check_equal("CTRL write response", {30'b0, resp}, {30'b0, msg_pkg::RespOkay});
  endtask

  task automatic wait_for_done();
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    axi_read(msg_pkg::AddrStatus, status, resp);
    while (!status[msg_pkg::StatusDoneBit]) begin
      if (polls == DonePollLimit) begin
        abort_run("Timeout: STATUS done bit never set after process");
      end
      polls++;
      axi_read(msg_pkg::AddrStatus, status, resp);
    end
    check_equal("STATUS empty after done", {31'b0, status[msg_pkg::StatusEmptyBit]}, 32'd1);
  endtask

  task automatic process_and_compare(input string label);
    logic [31:0] data;
    logic [1:0]  resp;
    write_ctrl_bit(msg_pkg::CtrlProcessBit);
    wait_for_done();
    axi_read(msg_pkg::AddrDigest, data, resp);
    check_equal($sformatf("%s DIGEST", label), data, {model_sum2[15:0], model_sum1[15:0]});
    axi_read(msg_pkg::AddrByteCnt, data, resp);
    check_equal($sformatf("%s BYTE_COUNT", label), data, model_count);
  endtask

  // Empty set, everything else zero
  task automatic check_idle(input string label);
    logic [31:0] data;
    logic [31:0] exp;
    logic [1:0]  resp;
    exp = '0;
    exp[msg_pkg::StatusEmptyBit] = 1'b1;
    axi_read(msg_pkg::AddrStatus, data, resp);
    check_equal($sformatf("%s STATUS", label), data, exp);
    axi_read(msg_pkg::AddrDigest, data, resp);
    check_equal($sformatf("%s DIGEST", label), data, 32'd0);
    axi_read(msg_pkg::AddrByteCnt, data, resp);
    check_equal($sformatf("%s BYTE_COUNT", label), data, 32'd0);
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    int unsigned depth;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    rst_n   = 1'b0;
    seed_val = $urandom(32'h263c);
    model_reset();

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_idle("after reset");

    // Random strobes, flush of a partial word
    send_random_words(9);
    process_and_compare("first run");

    // Clear after done, then a fresh run
    write_ctrl_bit(msg_pkg::CtrlClearBit);
    check_idle("after clear");
    model_reset();
    send_random_words(13);
    process_and_compare("second run");

    // Ten full words back to back
    write_ctrl_bit(msg_pkg::CtrlClearBit);
    model_reset();
    for (int i = 0; i < 10; i++) begin
      send_message($urandom, 4'hF);
    end
    // Writes land at most every other cycle and the absorber takes a word
    // every other cycle, so no more than one word waits in the FIFO
    axi_read(msg_pkg::AddrStatus, data, resp);
    depth = data[msg_pkg::StatusDepthLsb +: msg_pkg::MsgDepthW];
    check_equal("STATUS full flag", {31'b0, data[msg_pkg::StatusFullBit]}, 32'd0);
    assert (depth <= 1)
      else abort_run($sformatf("[FAIL] %0t ns: STATUS depth %0d above one word", $time, depth));
    process_and_compare("burst run");

    // Unmapped accesses and a zero-strobe write
    write_ctrl_bit(msg_pkg::CtrlClearBit);
    model_reset();
    axi_read(32'h20, data, resp);
    check_equal("unmapped read response", {30'b0, resp}, {30'b0, msg_pkg::RespSlvErr});
    axi_write(32'h24, 32'h1234_5678, 4'hF, resp);
    check_equal("unmapped write response", {30'b0, resp}, {30'b0, msg_pkg::RespSlvErr});
    send_message(32'hA5C3_0F81, 4'hF);
    axi_write(msg_pkg::AddrMsg, 32'hFFFF_FFFF, 4'h0, resp);
    check_equal("zero strobe write response", {30'b0, resp}, {30'b0, msg_pkg::RespOkay});
    process_and_compare("zero strobe run");

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: design/msg_subsys_top.sv
`timescale 1ns/1ps

module msg_subsys_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // AXI4-Lite slave
  input  msg_pkg::addr_t     s_awaddr_i,
  input  logic               s_awvalid_i,
  output logic               s_awready_o,
  input  msg_pkg::msg_word_t s_wdata_i,
  input  msg_pkg::msg_strb_t s_wstrb_i,
  input  logic               s_wvalid_i,
  output logic               s_wready_o,
  output logic [1:0]         s_bresp_o,
  output logic               s_bvalid_o,
  input  logic               s_bready_i,
  input  msg_pkg::addr_t     s_araddr_i,
  input  logic               s_arvalid_i,
  output logic               s_arready_o,
  output msg_pkg::msg_word_t s_rdata_o,
  output logic [1:0]         s_rresp_o,
  output logic               s_rvalid_o,
  input  logic               s_rready_i
);

  // Register block to buffer
  logic                msg_valid;
  msg_pkg::msg_word_t  msg_data;
  msg_pkg::msg_strb_t  msg_strb;
  logic                msg_ready;
  logic                process;
  logic                clear;
  logic                fifo_empty;
  logic                fifo_full;
  msg_pkg::msg_depth_t fifo_depth;
  logic                flush_done;

  // Buffer to absorber
  logic                abs_valid;
  msg_pkg::msg_word_t  abs_data;
  msg_pkg::msg_strb_t  abs_strb;
  logic                abs_ready;
  logic                abs_busy;

  // Results back to the register block
  msg_pkg::digest_t    digest;
  msg_pkg::byte_cnt_t  byte_cnt;

  msg_axil_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .s_awaddr_i   (s_awaddr_i),
    .s_awvalid_i  (s_awvalid_i),
    .s_awready_o  (s_awready_o),
    .s_wdata_i    (s_wdata_i),
    .s_wstrb_i    (s_wstrb_i),
    .s_wvalid_i   (s_wvalid_i),
    .s_wready_o   (s_wready_o),
    .s_bresp_o    (s_bresp_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .s_araddr_i   (s_araddr_i),
    .s_arvalid_i  (s_arvalid_i),
    .s_arready_o  (s_arready_o),
    .s_rdata_o    (s_rdata_o),
    .s_rresp_o    (s_rresp_o),
    .s_rvalid_o   (s_rvalid_o),
    .s_rready_i   (s_rready_i),
    .msg_valid_o  (msg_valid),
    .msg_data_o   (msg_data),
    .msg_strb_o   (msg_strb),
    .msg_ready_i  (msg_ready),
    .process_o    (process),
    .clear_o      (clear),
    .fifo_empty_i (fifo_empty),
    .fifo_full_i  (fifo_full),
    .fifo_depth_i (fifo_depth),
    .flush_done_i (flush_done),
    .digest_i     (digest),
    .byte_cnt_i   (byte_cnt)
  );

  msg_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .msg_valid_i  (msg_valid),
    .msg_data_i   (msg_data),
    .msg_strb_i   (msg_strb),
    .msg_ready_o  (msg_ready),
    .abs_valid_o  (abs_valid),
    .abs_data_o   (abs_data),
    .abs_strb_o   (abs_strb),
    .abs_ready_i  (abs_ready),
    .abs_busy_i   (abs_busy),
    .process_i    (process),
    .clear_i      (clear),
    .fifo_empty_o (fifo_empty),
    .fifo_full_o  (fifo_full),
    .fifo_depth_o (fifo_depth),
    .flush_done_o (flush_done)
  );

  msg_absorber u_absorber (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .abs_valid_i (abs_valid),
    .abs_data_i  (abs_data),
    .abs_strb_i  (abs_strb),
    .abs_ready_o (abs_ready),
    .abs_busy_o  (abs_busy),
    .clear_i     (clear),
    .digest_o    (digest),
    .byte_cnt_o  (byte_cnt)
  );

endmodule

// File: design/msg_absorber.sv
`timescale 1ns/1ps

module msg_absorber (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               abs_valid_i,
  input  msg_pkg::msg_word_t abs_data_i,
  input  msg_pkg::msg_strb_t abs_strb_i,
  output logic               abs_ready_o,
  output logic               abs_busy_o,
  input  logic               clear_i,
  output msg_pkg::digest_t   digest_o,
  output msg_pkg::byte_cnt_t byte_cnt_o
);

  // One Fletcher step, sum1 then sum2, both modulo 65536
  function automatic msg_pkg::digest_t absorb_byte(msg_pkg::digest_t d, logic [7:0] b);
    logic [15:0] s1;
    logic [15:0] s2;
    s1 = d[15:0] + {8'h00, b};
    s2 = d[31:16] + s1;
    return {s2, s1};
  endfunction

  logic               busy_q;
  logic               fire;
  logic [15:0]        hi_data_q;
  logic [1:0]         hi_strb_q;
  logic [15:0]        half_data;
  logic [1:0]         half_strb;
  msg_pkg::digest_t   digest_q;
  msg_pkg::digest_t   digest_d;
  msg_pkg::byte_cnt_t cnt_q;
  msg_pkg::byte_cnt_t cnt_d;

  // Ready in the first cycle of a word, busy in the second
  assign abs_ready_o = !busy_q;
  assign abs_busy_o  = busy_q;
  assign fire        = abs_valid_i && abs_ready_o;

  // Bytes 0 and 1 straight from the bus, bytes 2 and 3 from the latch
  assign half_data = busy_q ? hi_data_q : abs_data_i[15:0];
  assign half_strb = busy_q ? hi_strb_q : abs_strb_i[1:0];

  always_comb begin
    digest_d = digest_q;
    cnt_d    = cnt_q;
    for (int i = 0; i < 2; i++) begin
      if (half_strb[i]) begin
        digest_d = absorb_byte(digest_d, half_data[8*i +: 8]);
        cnt_d    = cnt_d + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      digest_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      busy_q   <= 1'b0;
      digest_q <= '0;
      cnt_q    <= '0;
    end else if (fire || busy_q) begin
      busy_q   <= fire;
      digest_q <= digest_d;
      cnt_q    <= cnt_d;
    end
  end

  // Upper half of the word kept for the second cycle
  always_ff @(posedge clk_i) begin
    if (fire) begin
      hi_data_q <= abs_data_i[31:16];
      hi_strb_q <= abs_strb_i[3:2];
    end
  end

  assign digest_o   = digest_q;
  assign byte_cnt_o = cnt_q;

endmodule

// File: design/msg_fifo.sv
`timescale 1ns/1ps

module msg_fifo (
  input  logic                clk_i,
  input  logic                rst_ni,

  // From the register block
  input  logic                msg_valid_i,
  input  msg_pkg::msg_word_t  msg_data_i,
  input  msg_pkg::msg_strb_t  msg_strb_i,
  output logic                msg_ready_o,

  // To the absorber
  output logic                abs_valid_o,
  output msg_pkg::msg_word_t  abs_data_o,
  output msg_pkg::msg_strb_t  abs_strb_o,
  input  logic                abs_ready_i,
  input  logic                abs_busy_i,

  input  logic                process_i,
  input  logic                clear_i,
  output logic                fifo_empty_o,
  output logic                fifo_full_o,
  output msg_pkg::msg_depth_t fifo_depth_o,
  output logic                flush_done_o
);

  typedef enum logic [1:0] {
    // Accepting words, waiting for process
    FlushIdle,
    // Packer pushing out its remainder
    FlushPacker,
    // Draining the FIFO and the absorber
    FlushFifo,
    // Finished, waiting for clear
    FlushClear
  } flush_st_e;

  flush_st_e            st_q;
  flush_st_e            st_d;
  logic                 st_idle;
  logic                 pk_in_valid;
  logic                 pk_in_ready;
  logic                 pk_valid;
  msg_pkg::msg_word_t   pk_data;
  msg_pkg::msg_strb_t   pk_strb;
  logic                 pk_flush;
  logic                 pk_flush_done;
  logic                 push;
  logic                 pop;
  msg_pkg::msg_word_t   mem_data [msg_pkg::MsgDepth];
  msg_pkg::msg_strb_t   mem_strb [msg_pkg::MsgDepth];
  logic [msg_pkg::MsgPtrW-1:0] wptr_q;
  logic [msg_pkg::MsgPtrW-1:0] rptr_q;
  msg_pkg::msg_depth_t  depth_q;

  assign st_idle = (st_q == FlushIdle);

  // New words only between clear and process
  assign pk_in_valid = msg_valid_i && st_idle;
  assign msg_ready_o = pk_in_ready && st_idle;
  // Process outside idle is dropped
  assign pk_flush    = process_i && st_idle;

  msg_packer u_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (pk_in_valid),
    .in_data_i    (msg_data_i),
    .in_strb_i    (msg_strb_i),
    .in_ready_o   (pk_in_ready),
    .out_valid_o  (pk_valid),
    .out_data_o   (pk_data),
    .out_strb_o   (pk_strb),
    .out_ready_i  (!fifo_full_o),
    .flush_i      (pk_flush),
    .clear_i      (clear_i),
    .flush_done_o (pk_flush_done)
  );

  //////////////////////////////////////////////////////////////////////
  // Circular buffer
  //////////////////////////////////////////////////////////////////////

  assign fifo_full_o  = (depth_q == msg_pkg::MsgDepthW'(msg_pkg::MsgDepth));
  assign fifo_empty_o = (depth_q == '0);
  assign fifo_depth_o = depth_q;

  assign push = pk_valid && !fifo_full_o;
  assign pop  = abs_valid_o && abs_ready_i;

  // Read side shows the head entry, a write shows up one cycle later
  assign abs_valid_o = !fifo_empty_o;
  assign abs_data_o  = mem_data[rptr_q];
  assign abs_strb_o  = mem_strb[rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      depth_q <= '0;
    end else if (clear_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      depth_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      // Depth follows push and pop together
      case ({push, pop})
        2'b10:   depth_q <= depth_q + 1'b1;
        2'b01:   depth_q <= depth_q - 1'b1;
        default: depth_q <= depth_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_data[wptr_q] <= pk_data;
      mem_strb[wptr_q] <= pk_strb;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Flush FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    st_d         = st_q;
    flush_done_o = 1'b0;
    case (st_q)
      FlushIdle: begin
        if (process_i) begin
          st_d = FlushPacker;
        end
      end
      FlushPacker: begin
        if (pk_flush_done) begin
          st_d = FlushFifo;
        end
      end
      FlushFifo: begin
        // Last word must also be through the absorber
        if (fifo_empty_o && !abs_busy_i) begin
          st_d         = FlushClear;
          flush_done_o = 1'b1;
        end
      end
      FlushClear: begin
        if (clear_i) begin
          st_d = FlushIdle;
        end
      end
      default: st_d = FlushIdle;
    endcase
    // Clear aborts a flush in any state
    if (clear_i) begin
      st_d = FlushIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= FlushIdle;
    end else begin
      st_q <= st_d;
    end
  end

endmodule

// File: design/msg_packer.sv
`timescale 1ns/1ps

module msg_packer (
  input  logic               clk_i,
  input  logic               rst_ni,

  // Strobed input words
  input  logic               in_valid_i,
  input  msg_pkg::msg_word_t in_data_i,
  input  msg_pkg::msg_strb_t in_strb_i,
  output logic               in_ready_o,

  // Packed output words
  output logic               out_valid_o,
  output msg_pkg::msg_word_t out_data_o,
  output msg_pkg::msg_strb_t out_strb_o,
  input  logic               out_ready_i,

  input  logic               flush_i,
  input  logic               clear_i,
  output logic               flush_done_o
);

  // Byte holding register, lowest byte is oldest
  logic [msg_pkg::PackHoldBytes-1:0][7:0] hold_q;
  logic [msg_pkg::PackHoldBytes-1:0][7:0] hold_d;
  logic [msg_pkg::PackCntW-1:0]           cnt_q;
  logic [msg_pkg::PackCntW-1:0]           cnt_d;
  logic [msg_pkg::PackCntW-1:0]           pos;
  logic                                   flush_q;
  logic                                   has_word;
  logic                                   in_fire;
  logic                                   out_fire;

  assign has_word = (cnt_q >= msg_pkg::MsgBytes);

  // Full word, or the remainder while flushing
  assign out_valid_o = has_word || (flush_q && (cnt_q != '0));
  assign out_data_o  = hold_q[msg_pkg::MsgBytes-1:0];

  // Partial word strobes sit on the low bytes
  always_comb begin
    for (int i = 0; i < msg_pkg::MsgBytes; i++) begin
      out_strb_o[i] = (i < cnt_q);
    end
  end

  // Only append when fewer than 4 bytes are held, so pop and append never overlap
  assign in_ready_o   = !has_word && !flush_q;
  assign flush_done_o = flush_q && (cnt_q == '0);

  assign in_fire  = in_valid_i && in_ready_o;
  assign out_fire = out_valid_o && out_ready_i;

  always_comb begin
    hold_d = hold_q;
    cnt_d  = cnt_q;
    pos    = cnt_q;
    if (out_fire) begin
      // Shift the leftover bytes down
      for (int i = 0; i < msg_pkg::PackHoldBytes - msg_pkg::MsgBytes; i++) begin
        hold_d[i] = hold_q[i+msg_pkg::MsgBytes];
      end
      cnt_d = has_word ? cnt_q - msg_pkg::PackCntW'(msg_pkg::MsgBytes) : '0;
    end else if (in_fire) begin
      // Append strobed bytes in byte order
      for (int i = 0; i < msg_pkg::MsgBytes; i++) begin
        if (in_strb_i[i]) begin
          hold_d[pos] = in_data_i[8*i +: 8];
          pos = pos + 1'b1;
        end
      end
      cnt_d = pos;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      flush_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q   <= '0;
      flush_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      if (flush_i) begin
        flush_q <= 1'b1;
      end else if (flush_done_o) begin
        flush_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    hold_q <= hold_d;
  end

endmodule

// File: design/msg_axil_regs.sv
`timescale 1ns/1ps

module msg_axil_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // AXI4-Lite slave
  input  msg_pkg::addr_t       s_awaddr_i,
  input  logic                 s_awvalid_i,
  output logic                 s_awready_o,
  input  msg_pkg::msg_word_t   s_wdata_i,
  input  msg_pkg::msg_strb_t   s_wstrb_i,
  input  logic                 s_wvalid_i,
  output logic                 s_wready_o,
  output logic [1:0]           s_bresp_o,
  output logic                 s_bvalid_o,
  input  logic                 s_bready_i,
  input  msg_pkg::addr_t       s_araddr_i,
  input  logic                 s_arvalid_i,
  output logic                 s_arready_o,
  output msg_pkg::msg_word_t   s_rdata_o,
  output logic [1:0]           s_rresp_o,
  output logic                 s_rvalid_o,
  input  logic                 s_rready_i,

  // Message words to the buffer
  output logic                 msg_valid_o,
  output msg_pkg::msg_word_t   msg_data_o,
  output msg_pkg::msg_strb_t   msg_strb_o,
  input  logic                 msg_ready_i,

  // Control pulses and buffer status
  output logic                 process_o,
  output logic                 clear_o,
  input  logic                 fifo_empty_i,
  input  logic                 fifo_full_i,
  input  msg_pkg::msg_depth_t  fifo_depth_i,
  input  logic                 flush_done_i,

  // Absorber results
  input  msg_pkg::digest_t     digest_i,
  input  msg_pkg::byte_cnt_t   byte_cnt_i
);

  logic               wr_is_msg;
  logic               wr_is_ctrl;
  logic               wr_mapped;
  logic               wr_fire;
  logic               ctrl_wr;
  logic               rd_fire;
  logic               rd_mapped;
  logic               done_q;
  logic               bvalid_q;
  logic               rvalid_q;
  logic [1:0]         bresp_q;
  logic [1:0]         rresp_q;
  msg_pkg::msg_word_t wmask;
  msg_pkg::msg_word_t status;
  msg_pkg::msg_word_t rdata_d;
  msg_pkg::msg_word_t rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Write path
  //////////////////////////////////////////////////////////////////////

  assign wr_is_msg  = (s_awaddr_i == msg_pkg::AddrMsg);
  assign wr_is_ctrl = (s_awaddr_i == msg_pkg::AddrCtrl);
  // Read-only registers accept writes and ignore them
  assign wr_mapped  = wr_is_msg || wr_is_ctrl ||
                      (s_awaddr_i == msg_pkg::AddrStatus) ||
                      (s_awaddr_i == msg_pkg::AddrDigest) ||
                      (s_awaddr_i == msg_pkg::AddrByteCnt);

  // Address and data taken together, MSG writes also need buffer space
  assign wr_fire = s_awvalid_i && s_wvalid_i && !bvalid_q &&
                   (!wr_is_msg || msg_ready_i);

  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;

  // Expand strobes to a byte mask
  always_comb begin
    for (int i = 0; i < msg_pkg::MsgBytes; i++) begin
      wmask[8*i +: 8] = {8{s_wstrb_i[i]}};
    end
  end

  // Masked word issued in the acceptance cycle, zero strobes drop it
  assign msg_valid_o = wr_fire && wr_is_msg && (|s_wstrb_i);
  assign msg_data_o  = s_wdata_i & wmask;
  assign msg_strb_o  = s_wstrb_i;

  // CTRL bits live in byte 0
  assign ctrl_wr   = wr_fire && wr_is_ctrl && s_wstrb_i[0];
  assign process_o = ctrl_wr && s_wdata_i[msg_pkg::CtrlProcessBit];
  assign clear_o   = ctrl_wr && s_wdata_i[msg_pkg::CtrlClearBit];

  // Response held until the master takes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q <= 1'b0;
      bresp_q  <= msg_pkg::RespOkay;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
      bresp_q  <= wr_mapped ? msg_pkg::RespOkay : msg_pkg::RespSlvErr;
    end else if (s_bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = bresp_q;

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  // Sticky done, set by the flush end and dropped by clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (clear_o) begin
      done_q <= 1'b0;
    end else if (flush_done_i) begin
      done_q <= 1'b1;
    end
  end

  always_comb begin
    status = '0;
    status[msg_pkg::StatusEmptyBit] = fifo_empty_i;
    status[msg_pkg::StatusFullBit]  = fifo_full_i;
    status[msg_pkg::StatusDoneBit]  = done_q;
    status[msg_pkg::StatusDepthLsb +: msg_pkg::MsgDepthW] = fifo_depth_i;
  end

  // MSG and CTRL read back as zero
  always_comb begin
    rdata_d   = '0;
    rd_mapped = 1'b1;
    case (s_araddr_i)
      msg_pkg::AddrMsg:     rdata_d = '0;
      msg_pkg::AddrCtrl:    rdata_d = '0;
      msg_pkg::AddrStatus:  rdata_d = status;
      msg_pkg::AddrDigest:  rdata_d = digest_i;
      msg_pkg::AddrByteCnt: rdata_d = byte_cnt_i;
      default:              rd_mapped = 1'b0;
    endcase
  end

  assign rd_fire     = s_arvalid_i && !rvalid_q;
  assign s_arready_o = rd_fire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rresp_q  <= msg_pkg::RespOkay;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
      rresp_q  <= rd_mapped ? msg_pkg::RespOkay : msg_pkg::RespSlvErr;
    end else if (s_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  // Read data captured with the address
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rdata_d;
    end
  end

  assign s_rvalid_o = rvalid_q;
  assign s_rresp_o  = rresp_q;
  assign s_rdata_o  = rdata_q;

endmodule

// File: design/msg_pkg.sv
package msg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Message word and byte lanes
  localparam int MsgWidth = 32;
  localparam int MsgBytes = MsgWidth / 8;

  // FIFO entries, fill level counts 0 to MsgDepth
  localparam int MsgDepth  = 8;
  localparam int MsgDepthW = 4;
  localparam int MsgPtrW   = $clog2(MsgDepth);

  // Packer keeps up to 3 leftover bytes plus one incoming word
  localparam int PackHoldBytes = 2 * MsgBytes - 1;
  localparam int PackCntW      = 3;

  // Bus address width
  localparam int AddrWidth = 32;

  typedef logic [MsgWidth-1:0]  msg_word_t;
  typedef logic [MsgBytes-1:0]  msg_strb_t;
  typedef logic [MsgDepthW-1:0] msg_depth_t;
  // Upper half sum2, lower half sum1
  typedef logic [31:0]          digest_t;
  typedef logic [31:0]          byte_cnt_t;
  typedef logic [AddrWidth-1:0] addr_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam addr_t AddrMsg     = 32'h00;
  localparam addr_t AddrCtrl    = 32'h04;
  localparam addr_t AddrStatus  = 32'h08;
  localparam addr_t AddrDigest  = 32'h0C;
  localparam addr_t AddrByteCnt = 32'h10;

  // CTRL fields
  localparam int CtrlProcessBit = 0;
  localparam int CtrlClearBit   = 1;

  // STATUS fields
  localparam int StatusEmptyBit = 0;
  localparam int StatusFullBit  = 1;
  localparam int StatusDoneBit  = 2;
  localparam int StatusDepthLsb = 4;

  // AXI response codes
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

endpackage
